//--- hdl/rv_core_pkg.sv
package rv_core_pkg;

	localparam int XLEN = 32;

	// basic widths
	typedef logic [XLEN-1:0] word_t;
	typedef logic [XLEN-1:0] addr_t;
	typedef logic [4:0]      reg_idx_t;
	typedef logic [3:0]      alu_op_t;
	typedef logic [6:0]      opcode_t;
	typedef logic [2:0]      funct3_t;
	typedef logic [6:0]      funct7_t;

	// alu codes are {funct7[5], funct3} so decode can build them directly
	localparam alu_op_t ALU_ADD  = 4'b0000;
	localparam alu_op_t ALU_SUB  = 4'b1000;
	localparam alu_op_t ALU_SLL  = 4'b0001;
	localparam alu_op_t ALU_SLT  = 4'b0010;
	localparam alu_op_t ALU_SLTU = 4'b0011;
	localparam alu_op_t ALU_XOR  = 4'b0100;
	localparam alu_op_t ALU_SRL  = 4'b0101;
	localparam alu_op_t ALU_SRA  = 4'b1101;
	localparam alu_op_t ALU_OR   = 4'b0110;
	localparam alu_op_t ALU_AND  = 4'b0111;

	// major opcodes
	localparam opcode_t OPC_OP     = 7'b0110011;
	localparam opcode_t OPC_OP_IMM = 7'b0010011;
	localparam opcode_t OPC_LUI    = 7'b0110111;
	localparam opcode_t OPC_AUIPC  = 7'b0010111;
	localparam opcode_t OPC_JAL    = 7'b1101111;
	localparam opcode_t OPC_BRANCH = 7'b1100011;

	// funct3 values decode needs to look at
	localparam funct3_t F3_ADD  = 3'b000;
	localparam funct3_t F3_SLL  = 3'b001;
	localparam funct3_t F3_SR   = 3'b101;
	localparam funct3_t F3_BEQ  = 3'b000;
	localparam funct3_t F3_BNE  = 3'b001;
	localparam funct3_t F3_BLT  = 3'b100;
	localparam funct3_t F3_BGE  = 3'b101;
	localparam funct3_t F3_BLTU = 3'b110;
	localparam funct3_t F3_BGEU = 3'b111;

	// sub / sra marker
	localparam funct7_t F7_ALT = 7'b0100000;

	localparam addr_t RESET_PC = 32'h8000_0000;

	typedef struct packed {
		logic  valid;
		addr_t pc;
		word_t inst;
	} if_id_t;

	typedef struct packed {
		logic     valid;
		addr_t    pc;
		word_t    operand_a;
		word_t    operand_b;
		alu_op_t  alu_op;
		logic     wen;
		reg_idx_t rd;
	} id_ex_t;

	typedef struct packed {
		logic     valid;
		addr_t    pc;
		logic     wen;
		reg_idx_t rd;
		word_t    result;
	} ex_wb_t;

endpackage

//--- hdl/rv_fetch.sv
`timescale 1ns/10ps

module rv_fetch import rv_core_pkg::*; (
	input  logic   clock,
	input  logic   rst_n_i,
	input  word_t  inst_i,
	input  logic   inst_valid_i,
	input  logic   redirect_i,
	input  addr_t  redirect_pc_i,
	output addr_t  inst_addr_o,
	output if_id_t if_id_o
);

	addr_t pc;

	// memory answers in the same cycle
	assign inst_addr_o = pc;

	always_ff @(posedge clock or negedge rst_n_i) begin
		if (!rst_n_i) begin
			pc <= RESET_PC;
			if_id_o <= '0;
		end else if (redirect_i) begin
			// the word fetched this cycle is on the wrong path
			pc <= redirect_pc_i;
			if_id_o.valid <= 1'b0;
			if_id_o.pc <= pc;
			if_id_o.inst <= inst_i;
		end else if (inst_valid_i) begin
			pc <= pc + 32'd4;
			if_id_o.valid <= 1'b1;
			if_id_o.pc <= pc;
			if_id_o.inst <= inst_i;
		end else begin
			// no word this cycle, pc holds and a bubble goes down
			if_id_o.valid <= 1'b0;
		end
	end

endmodule

//--- hdl/rv_decode.sv
`timescale 1ns/10ps

module rv_decode import rv_core_pkg::*; (
	input  logic     clock,
	input  logic     rst_n_i,
	input  if_id_t   if_id_i,
	input  word_t    rs1_val_i,
	input  word_t    rs2_val_i,
	output reg_idx_t rs1_o,
	output reg_idx_t rs2_o,
	output logic     redirect_o,
	output addr_t    redirect_pc_o,
	output id_ex_t   id_ex_o
);

	word_t    inst;
	opcode_t  opcode;
	funct3_t  funct3;
	funct7_t  funct7;
	reg_idx_t rd;
	word_t    imm_i;
	word_t    imm_u;
	word_t    imm_b;
	word_t    imm_j;
	logic     op_legal;
	logic     imm_legal;
	logic     branch_cond;
	logic     writes;
	logic     taken;
	addr_t    target;
	word_t    operand_a;
	word_t    operand_b;
	alu_op_t  alu_op;

	// field extraction
	assign inst = if_id_i.inst;
	assign opcode = inst[6:0];
	assign rd = inst[11:7];
	assign funct3 = inst[14:12];
	assign rs1_o = inst[19:15];
	assign rs2_o = inst[24:20];
	assign funct7 = inst[31:25];

	assign imm_i = {{20{inst[31]}}, inst[31:20]};
	assign imm_u = {inst[31:12], 12'b0};
	assign imm_b = {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
	assign imm_j = {{11{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};

	// funct7 must be zero except for sub and sra
	assign op_legal = (funct7 == '0) ||
		(funct7 == F7_ALT && (funct3 == F3_ADD || funct3 == F3_SR));
	assign imm_legal = (funct3 != F3_SLL && funct3 != F3_SR) || (funct7 == '0) ||
		(funct7 == F7_ALT && funct3 == F3_SR);

	// branch compare on the bypassed operands
	always_comb begin
		case (funct3)
			F3_BEQ:  branch_cond = rs1_val_i == rs2_val_i;
			F3_BNE:  branch_cond = rs1_val_i != rs2_val_i;
			F3_BLT:  branch_cond = $signed(rs1_val_i) < $signed(rs2_val_i);
			F3_BGE:  branch_cond = $signed(rs1_val_i) >= $signed(rs2_val_i);
			F3_BLTU: branch_cond = rs1_val_i < rs2_val_i;
			F3_BGEU: branch_cond = rs1_val_i >= rs2_val_i;
			default: branch_cond = 1'b0;
		endcase
	end

	always_comb begin
		operand_a = rs1_val_i;
		operand_b = rs2_val_i;
		alu_op = ALU_ADD;
		writes = 1'b0;
		taken = 1'b0;
		target = if_id_i.pc + imm_b;
		case (opcode)
			OPC_OP: begin
				alu_op = {funct7[5], funct3};
				writes = op_legal;
			end
			OPC_OP_IMM: begin
				// only srai carries the alt bit, addi has no subtract form
				operand_b = imm_i;
				alu_op = {funct3 == F3_SR && funct7[5], funct3};
				writes = imm_legal;
			end
			OPC_LUI: begin
				operand_a = '0;
				operand_b = imm_u;
				writes = 1'b1;
			end
			OPC_AUIPC: begin
				operand_a = if_id_i.pc;
				operand_b = imm_u;
				writes = 1'b1;
			end
			OPC_JAL: begin
				// link value pc + 4 goes through the adder
				operand_a = if_id_i.pc;
				operand_b = 32'd4;
				writes = 1'b1;
				taken = 1'b1;
				target = if_id_i.pc + imm_j;
			end
			OPC_BRANCH: begin
				taken = branch_cond;
			end
			default: begin
				writes = 1'b0;
			end
		endcase
	end

	assign redirect_o = if_id_i.valid && taken;
	assign redirect_pc_o = target;

	always_ff @(posedge clock or negedge rst_n_i) begin
		if (!rst_n_i) begin
			id_ex_o <= '0;
		end else begin
			id_ex_o.valid <= if_id_i.valid;
			id_ex_o.pc <= if_id_i.pc;
			id_ex_o.operand_a <= operand_a;
			id_ex_o.operand_b <= operand_b;
			id_ex_o.alu_op <= alu_op;
			// x0 writes dropped here, later stages trust wen
			id_ex_o.wen <= if_id_i.valid && writes && (rd != '0);
			id_ex_o.rd <= rd;
		end
	end

endmodule

//--- hdl/rv_regfile.sv
`timescale 1ns/10ps

module rv_regfile import rv_core_pkg::*; (
	input  logic     clock,
	input  logic     rst_n_i,
	input  reg_idx_t rs1_i,
	input  reg_idx_t rs2_i,
	input  logic     wen_i,
	input  reg_idx_t rd_i,
	input  word_t    wdata_i,
	output word_t    rs1_val_o,
	output word_t    rs2_val_o
);

	// x0 has no storage
	word_t regs [1:31];

	always_ff @(posedge clock or negedge rst_n_i) begin
		if (!rst_n_i) begin
			for (int i = 1; i < 32; i++) begin
				regs[i] <= '0;
			end
		end else if (wen_i && rd_i != '0) begin
			regs[rd_i] <= wdata_i;
		end
	end

	assign rs1_val_o = (rs1_i == '0) ? '0 : regs[rs1_i];
	assign rs2_val_o = (rs2_i == '0) ? '0 : regs[rs2_i];

endmodule

//--- hdl/rv_bypass.sv
`timescale 1ns/10ps

module rv_bypass import rv_core_pkg::*; (
	input  reg_idx_t rs1_i,
	input  reg_idx_t rs2_i,
	input  word_t    rf_rs1_i,
	input  word_t    rf_rs2_i,
	input  logic     ex_wen_i,
	input  reg_idx_t ex_rd_i,
	input  word_t    ex_result_i,
	input  ex_wb_t   wb_i,
	output word_t    rs1_val_o,
	output word_t    rs2_val_o
);

	// youngest producer wins, wen is never set for x0
	function automatic word_t pick(input reg_idx_t rs, input word_t rf_val);
		word_t val;
		if (ex_wen_i && ex_rd_i == rs) begin
			val = ex_result_i;
		end else if (wb_i.wen && wb_i.rd == rs) begin
			val = wb_i.result;
		end else begin
			val = rf_val;
		end
		return val;
	endfunction

	always_comb begin
		rs1_val_o = pick(rs1_i, rf_rs1_i);
		rs2_val_o = pick(rs2_i, rf_rs2_i);
	end

endmodule

//--- hdl/rv_execute.sv
`timescale 1ns/10ps

module rv_execute import rv_core_pkg::*; (
	input  logic   clock,
	input  logic   rst_n_i,
	input  id_ex_t id_ex_i,
	output word_t  ex_result_o,
	output ex_wb_t ex_wb_o
);

	word_t      a;
	word_t      b;
	logic [4:0] shamt;
	word_t      result;

	assign a = id_ex_i.operand_a;
	assign b = id_ex_i.operand_b;
	assign shamt = b[4:0];

	always_comb begin
		case (id_ex_i.alu_op)
			ALU_ADD:  result = a + b;
			ALU_SUB:  result = a - b;
			ALU_SLL:  result = a << shamt;
			ALU_SLT:  result = {{(XLEN-1){1'b0}}, $signed(a) < $signed(b)};
			ALU_SLTU: result = {{(XLEN-1){1'b0}}, a < b};
			ALU_XOR:  result = a ^ b;
			ALU_SRL:  result = a >> shamt;
			ALU_SRA:  result = $signed(a) >>> shamt;
			ALU_OR:   result = a | b;
			ALU_AND:  result = a & b;
			default:  result = '0;
		endcase
	end

	// also feeds the bypass unit
	assign ex_result_o = result;

	always_ff @(posedge clock or negedge rst_n_i) begin
		if (!rst_n_i) begin
			ex_wb_o <= '0;
		end else begin
			ex_wb_o.valid <= id_ex_i.valid;
			ex_wb_o.pc <= id_ex_i.pc;
			ex_wb_o.wen <= id_ex_i.wen;
			ex_wb_o.rd <= id_ex_i.rd;
			ex_wb_o.result <= result;
		end
	end

endmodule

//--- hdl/rv_core.sv
`timescale 1ns/10ps

module rv_core import rv_core_pkg::*; (
	input  logic     clock,
	input  logic     rst_n_i,
	input  word_t    inst_i,
	input  logic     inst_valid_i,
	output addr_t    inst_addr_o,
	output logic     retire_valid_o,
	output addr_t    retire_pc_o,
	output logic     retire_wen_o,
	output reg_idx_t retire_rd_o,
	output word_t    retire_data_o
);

	if_id_t   if_id;
	id_ex_t   id_ex;
	ex_wb_t   ex_wb;
	logic     redirect;
	addr_t    redirect_pc;
	reg_idx_t rs1;
	reg_idx_t rs2;
	word_t    rf_rs1;
	word_t    rf_rs2;
	word_t    rs1_val;
	word_t    rs2_val;
	word_t    ex_result;

	rv_fetch u_fetch (
		.clock         (clock),
		.rst_n_i       (rst_n_i),
		.inst_i        (inst_i),
		.inst_valid_i  (inst_valid_i),
		.redirect_i    (redirect),
		.redirect_pc_i (redirect_pc),
		.inst_addr_o   (inst_addr_o),
		.if_id_o       (if_id)
	);

	rv_decode u_decode (
		.clock         (clock),
		.rst_n_i       (rst_n_i),
		.if_id_i       (if_id),
		.rs1_val_i     (rs1_val),
		.rs2_val_i     (rs2_val),
		.rs1_o         (rs1),
		.rs2_o         (rs2),
		.redirect_o    (redirect),
		.redirect_pc_o (redirect_pc),
		.id_ex_o       (id_ex)
	);

	// written from the writeback register
	rv_regfile u_regfile (
		.clock     (clock),
		.rst_n_i   (rst_n_i),
		.rs1_i     (rs1),
		.rs2_i     (rs2),
		.wen_i     (ex_wb.wen),
		.rd_i      (ex_wb.rd),
		.wdata_i   (ex_wb.result),
		.rs1_val_o (rf_rs1),
		.rs2_val_o (rf_rs2)
	);

	rv_bypass u_bypass (
		.rs1_i       (rs1),
		.rs2_i       (rs2),
		.rf_rs1_i    (rf_rs1),
		.rf_rs2_i    (rf_rs2),
		.ex_wen_i    (id_ex.wen),
		.ex_rd_i     (id_ex.rd),
		.ex_result_i (ex_result),
		.wb_i        (ex_wb),
		.rs1_val_o   (rs1_val),
		.rs2_val_o   (rs2_val)
	);

	rv_execute u_execute (
		.clock       (clock),
		.rst_n_i     (rst_n_i),
		.id_ex_i     (id_ex),
		.ex_result_o (ex_result),
		.ex_wb_o     (ex_wb)
	);

	// retire port shows the writeback stage
	assign retire_valid_o = ex_wb.valid;
	assign retire_pc_o = ex_wb.pc;
	assign retire_wen_o = ex_wb.wen;
	assign retire_rd_o = ex_wb.rd;
	assign retire_data_o = ex_wb.result;

endmodule

//--- sim/rv_core_tb.sv
`timescale 1ns/10ps

module rv_core_tb import rv_core_pkg::*; ();

	localparam int CLK_PERIOD = 4;
	localparam int RESET_CYCLES = 16;
	localparam int PROG_WORDS = 400;
	localparam int IMEM_WORDS = 512;
	localparam int WATCHDOG_CYCLES = 4 * PROG_WORDS + RESET_CYCLES;
	localparam word_t NOP_WORD = 32'h0000_0013;
	localparam addr_t PROG_END = RESET_PC + 32'(PROG_WORDS * 4);
	localparam addr_t IMEM_BYTES = 32'(IMEM_WORDS * 4);

	typedef struct packed {
		addr_t    pc;
		logic     wen;
		reg_idx_t rd;
		word_t    data;
	} retire_t;

	logic     clock = 1'b0;
	logic     rst_n_i;
	word_t    inst_i;
	logic     inst_valid_i;
	addr_t    inst_addr_o;
	logic     retire_valid_o;
	addr_t    retire_pc_o;
	logic     retire_wen_o;
	reg_idx_t retire_rd_o;
	word_t    retire_data_o;

	integer  seed;
	word_t   imem [0:IMEM_WORDS-1];
	addr_t   imem_off;
	retire_t expected [$];
	int      n_checked = 0;
	int      value_errors = 0;
	int      other_errors = 0;

	rv_core u_dut (
		.clock          (clock),
		.rst_n_i        (rst_n_i),
		.inst_i         (inst_i),
		.inst_valid_i   (inst_valid_i),
		.inst_addr_o    (inst_addr_o),
		.retire_valid_o (retire_valid_o),
		.retire_pc_o    (retire_pc_o),
		.retire_wen_o   (retire_wen_o),
		.retire_rd_o    (retire_rd_o),
		.retire_data_o  (retire_data_o)
	);

	always #(CLK_PERIOD / 2) clock = ~clock;

	// instruction memory answers in the same cycle, NOP outside the image
	assign imem_off = inst_addr_o - RESET_PC;
	always_comb begin
		if (imem_off < IMEM_BYTES) begin
			inst_i = imem[imem_off[10:2]];
		end else begin
			inst_i = NOP_WORD;
		end
	end

	function automatic word_t next_rand();
		return $random(seed);
	endfunction

	// ALU results as the ISA tables define them
	function automatic word_t alu_model(input funct3_t f3, input logic alt, input word_t a,
		input word_t b);
		case (f3)
			3'd0: return alt ? a - b : a + b;
			3'd1: return a << b[4:0];
			3'd2: return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
			3'd3: return (a < b) ? 32'd1 : 32'd0;
			3'd4: return a ^ b;
			3'd5: begin
				if (alt) begin
					return $signed(a) >>> b[4:0];
				end
				return a >> b[4:0];
			end
			3'd6: return a | b;
			default: return a & b;
		endcase
	endfunction

	function automatic logic branch_taken(input funct3_t f3, input word_t a, input word_t b);
		case (f3)
			3'd0: return a == b;
			3'd1: return a != b;
			3'd4: return $signed(a) < $signed(b);
			3'd5: return $signed(a) >= $signed(b);
			3'd6: return a < b;
			default: return a >= b;
		endcase
	endfunction

	task automatic build_program();
		word_t       sel;
		word_t       r;
		funct3_t     f3;
		funct7_t     f7;
		reg_idx_t    rd;
		reg_idx_t    rs1;
		reg_idx_t    rs2;
		logic [12:0] boff;
		logic [20:0] joff;
		for (int i = 0; i < IMEM_WORDS; i++) begin
			imem[i] = NOP_WORD;
		end
		for (int i = 0; i < PROG_WORDS; i++) begin
			sel = next_rand();
			r = next_rand();
			// x0..x7 only so results get reused quickly
			rd = {2'b00, r[2:0]};
			rs1 = {2'b00, r[5:3]};
			rs2 = {2'b00, r[8:6]};
			f3 = r[11:9];
			f7 = (r[12] && (f3 == F3_ADD || f3 == F3_SR)) ? F7_ALT : 7'd0;
			// forward targets 8 to 36 bytes ahead
			boff = {8'd0, r[15:13], 2'b00} + 13'd8;
			joff = {16'd0, r[15:13], 2'b00} + 21'd8;
			case (sel[3:0])
				4'd10: imem[i] = {r[31:12], rd, OPC_LUI};
				4'd11: imem[i] = {r[31:12], rd, OPC_AUIPC};
				4'd12, 4'd13: begin
					if (f3 == 3'd2 || f3 == 3'd3) begin
						f3 = f3 - 3'd2;
					end
					imem[i] = {boff[12], boff[10:5], rs2, rs1, f3, boff[4:1], boff[11], OPC_BRANCH};
				end
				4'd14: imem[i] = {joff[20], joff[10:1], joff[11], joff[19:12], rd, OPC_JAL};
				default: begin
					if (sel[3:0] < 4'd5 || sel[3:0] == 4'd15) begin
						imem[i] = {f7, rs2, rs1, f3, rd, OPC_OP};
					end else if (f3 == F3_SLL || f3 == F3_SR) begin
						imem[i] = {f7, r[24:20], rs1, f3, rd, OPC_OP_IMM};
					end else begin
						imem[i] = {r[31:20], rs1, f3, rd, OPC_OP_IMM};
					end
				end
			endcase
		end
	endtask

	// one model retirement per executed instruction until the NOP tail
	task automatic run_model();
		word_t   xreg [0:31];
		addr_t   pc;
		addr_t   next_pc;
		addr_t   off;
		word_t   inst;
		word_t   a;
		word_t   b;
		word_t   imm_i;
		word_t   imm_b;
		word_t   imm_j;
		retire_t ret;
		logic    writes;
		for (int i = 0; i < 32; i++) begin
			xreg[i] = '0;
		end
		pc = RESET_PC;
		while (pc < PROG_END) begin
			off = pc - RESET_PC;
			inst = imem[off[10:2]];
			a = xreg[inst[19:15]];
			b = xreg[inst[24:20]];
			imm_i = {{20{inst[31]}}, inst[31:20]};
			imm_b = {{20{inst[31]}}, inst[7], inst[30:25], inst[11:8], 1'b0};
			imm_j = {{12{inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};
			next_pc = pc + 32'd4;
			ret.pc = pc;
			ret.rd = inst[11:7];
			ret.data = '0;
			writes = 1'b1;
			case (inst[6:0])
				OPC_OP: ret.data = alu_model(inst[14:12], inst[30], a, b);
				OPC_OP_IMM: ret.data = alu_model(inst[14:12], inst[14:12] == F3_SR && inst[30], a,
					imm_i);
				OPC_LUI: ret.data = {inst[31:12], 12'd0};
				OPC_AUIPC: ret.data = pc + {inst[31:12], 12'd0};
				OPC_JAL: begin
					ret.data = pc + 32'd4;
					next_pc = pc + imm_j;
				end
				OPC_BRANCH: begin
					writes = 1'b0;
					if (branch_taken(inst[14:12], a, b)) begin
						next_pc = pc + imm_b;
					end
				end
				default: writes = 1'b0;
			endcase
			ret.wen = writes && ret.rd != 5'd0;
			if (ret.wen) begin
				xreg[ret.rd] = ret.data;
			end
			expected.push_back(ret);
			pc = next_pc;
		end
	endtask

	task automatic check_addr(input string name, input addr_t got, input addr_t exp);
		if (got !== exp) begin
			value_errors++;
			$display("FAIL %s got %h expected %h", name, got, exp);
		end
	endtask

	task automatic check_reg(input string name, input reg_idx_t got, input reg_idx_t exp);
		if (got !== exp) begin
			value_errors++;
			$display("FAIL %s got %h expected %h", name, got, exp);
		end
	endtask

	task automatic check_word(input string name, input word_t got, input word_t exp);
		if (got !== exp) begin
			value_errors++;
			$display("FAIL %s got %h expected %h", name, got, exp);
		end
	endtask

	task automatic check_flag(input string name, input bit got, input bit exp);
		if (got !== exp) begin
			value_errors++;
			$display("FAIL %s got %h expected %h", name, got, exp);
		end
	endtask

	task automatic report_and_finish();
		$display("retired %0d of %0d, value errors %0d, other errors %0d",
			n_checked, expected.size(), value_errors, other_errors);
		if (value_errors == 0 && other_errors == 0) begin
			$display("RESULT: PASS");
		end else begin
			$display("RESULT: FAIL");
		end
		$finish;
	endtask

	// inst_valid_i drops on roughly one cycle in four
	always @(posedge clock) begin
		if (rst_n_i) begin
			inst_valid_i <= (next_rand() & 32'd3) != 32'd0;
		end else begin
			inst_valid_i <= 1'b0;
		end
	end

	// retirements are compared on the falling edge
	always @(negedge clock) begin
		if (!rst_n_i) begin
			if (retire_valid_o) begin
				other_errors++;
				$display("retire_valid_o went high while reset was asserted");
			end
		end else if (retire_valid_o && n_checked < expected.size()) begin
			check_addr("retire_pc_o", retire_pc_o, expected[n_checked].pc);
			check_flag("retire_wen_o", retire_wen_o, expected[n_checked].wen);
			check_reg("retire_rd_o", retire_rd_o, expected[n_checked].rd);
			if (expected[n_checked].wen) begin
				check_word("retire_data_o", retire_data_o, expected[n_checked].data);
			end
			n_checked++;
		end
	end

	initial begin
		seed = 32'h5711_b79e;
		rst_n_i = 1'b0;
		inst_valid_i = 1'b0;
		build_program();
		run_model();
		repeat (RESET_CYCLES) @(posedge clock);
		rst_n_i <= 1'b1;
		@(negedge clock);
		check_addr("inst_addr_o", inst_addr_o, RESET_PC);
		while (n_checked < expected.size()) begin
			@(negedge clock);
		end
		report_and_finish();
	end

	initial begin
		#(WATCHDOG_CYCLES * CLK_PERIOD);
		other_errors++;
		$display("timeout, retirements stopped after %0d of %0d", n_checked, expected.size());
		report_and_finish();
	end

endmodule

//--- rv_core.f
hdl/rv_core_pkg.sv
hdl/rv_fetch.sv
hdl/rv_decode.sv
hdl/rv_regfile.sv
hdl/rv_bypass.sv
hdl/rv_execute.sv
hdl/rv_core.sv
sim/rv_core_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# build the testbench with Verilator, run it and judge the log
cd "$(dirname "$0")" || exit 1
LOG=sim.log
rm -f "$LOG"

verilator --binary --timing -j 0 --top-module rv_core_tb -f rv_core.f -o Vrv_core_tb \
	&& ./obj_dir/Vrv_core_tb > "$LOG" 2>&1 \
	|| echo "build or simulation did not complete" >> "$LOG"

cat "$LOG"
grep -q "RESULT: FAIL" "$LOG" && exit 1
grep -q "RESULT: PASS" "$LOG" || exit 1
exit 0
